/* include/sdrc_settings.svh */
//--------------------------------------------------------------------------
// Fixed geometry, timing and mode-register values of the SDRAM controller
// Include wherever a width, a depth or a delay is needed
//--------------------------------------------------------------------------
`ifndef SDRC_SETTINGS_SVH
`define SDRC_SETTINGS_SVH

// Device geometry, one x16 part with four banks
`define SDRC_BA_W        2                       // Bank select bits
`define SDRC_ROW_W       12                      // Row bits, also sdr_addr width
`define SDRC_COL_W       8                       // Column bits
`define SDRC_APP_AW      (`SDRC_BA_W + `SDRC_ROW_W + `SDRC_COL_W)  // Bank, row, col
`define SDRC_DW          16                      // Data width, SDRAM and app

`define SDRC_FIFO_DEPTH  4                       // Buffered requests

// Timing in clock cycles
`define SDRC_INIT_WAIT   16                      // Power-up NOP time, short for sim
`define SDRC_TRP         2                       // Precharge period
`define SDRC_TRCD        2                       // ACTIVE to READ/WRITE
`define SDRC_TRC         6                       // ACTIVE to ACTIVE
`define SDRC_TRFC        4                       // Auto-refresh period
`define SDRC_TMRD        2                       // LOAD_MODE to first command
`define SDRC_CAS         2                       // CAS latency

// BL1, sequential, CAS 2, standard operation
`define SDRC_MODE_REG    12'h020

`endif

/* design/sdrc_pkg.sv */
//--------------------------------------------------------------------------
// Shared types of the SDRAM controller
// SDRAM command codes, transfer FSM states and the buffered request word
//--------------------------------------------------------------------------
`include "sdrc_settings.svh"

package sdrc_pkg;

  // Pin code {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    NOP          = 4'b0111,
    ACTIVE       = 4'b0011,
    READ         = 4'b0101,
    WRITE        = 4'b0100,
    PRECHARGE    = 4'b0010,
    AUTO_REFRESH = 4'b0001,
    LOAD_MODE    = 4'b0000
  } sdrc_cmd_e;

  typedef enum logic [2:0] {
    INIT_WAIT,                                   // Power-up NOPs
    INIT_PRE,                                    // After precharge all
    INIT_RFSH,                                   // Between auto refreshes
    INIT_MODE,                                   // After mode load
    IDLE,
    ACT,                                         // Row opening, tRCD
    RW,                                          // Column command
    RECOVER                                      // Rest of tRC
  } sdrc_xfr_state_e;

  // One access, 39 bits
  typedef struct packed {
    logic                   wr;                  // 1 = write
    logic [`SDRC_BA_W-1:0]  ba;
    logic [`SDRC_ROW_W-1:0] row;
    logic [`SDRC_COL_W-1:0] col;
    logic [`SDRC_DW-1:0]    data;                // Write data
  } sdrc_req_t;

endpackage

/* design/sdrc_req_if.sv */
//--------------------------------------------------------------------------
// Request path between decoder, buffer and transfer controller
// Single-cycle push and pop, no handshake inside the core
//--------------------------------------------------------------------------
interface sdrc_req_if (
  input logic clk
);
  import sdrc_pkg::*;

  logic      push;                               // Write side strobe
  logic      full;
  sdrc_req_t push_req;
  logic      pop;                                // Read side strobe
  logic      empty;
  sdrc_req_t pop_req;                            // Oldest entry

  modport producer (output push, output push_req, input full);
  modport buffer   (input clk, input push, input push_req, output full,
                    input pop, output empty, output pop_req);
  modport consumer (output pop, input empty, input pop_req);

endinterface

/* design/sdrc_req_gen.sv */
//--------------------------------------------------------------------------
// Application request port of the SDRAM controller
// Runs the four-phase req/ack handshake and decodes the flat address
// into bank, row and column before pushing into the request buffer
//--------------------------------------------------------------------------
`include "sdrc_settings.svh"

module sdrc_req_gen (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    app_req,         // Held until ack
  input  logic [`SDRC_APP_AW-1:0] app_req_addr,
  input  logic                    app_req_wr_n,    // 0 write, 1 read
  input  logic [`SDRC_DW-1:0]     app_wr_data,
  output logic                    app_req_ack,
  sdrc_req_if.producer            req
);

  typedef enum logic [1:0] {
    IDLE,                                          // Waiting for app_req
    ACKED,                                         // Ack high until req drops
    WAIT_DROP                                      // Turnaround after ack falls
  } gen_state_e;

  localparam int ROW_LSB = `SDRC_COL_W;
  localparam int BA_LSB  = `SDRC_COL_W + `SDRC_ROW_W;

  gen_state_e state;

  // Push only on a fresh request with room
  assign req.push = (state == IDLE) && app_req && !req.full;

  // Address layout is bank, row, column from MSB down
  always_comb begin
    req.push_req.wr   = ~app_req_wr_n;
    req.push_req.ba   = app_req_addr[BA_LSB +: `SDRC_BA_W];
    req.push_req.row  = app_req_addr[ROW_LSB +: `SDRC_ROW_W];
    req.push_req.col  = app_req_addr[`SDRC_COL_W-1:0];
    req.push_req.data = app_wr_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= IDLE;
      app_req_ack <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (req.push) begin                      // Stalls here while full
            state       <= ACKED;
            app_req_ack <= 1'b1;                   // Cycle after the push
          end
        end
        ACKED: begin
          if (!app_req) begin                      // Phase 3 seen
            state       <= WAIT_DROP;
            app_req_ack <= 1'b0;
          end
        end
        WAIT_DROP: state <= IDLE;                  // Let the app see ack low
        default:   state <= IDLE;
      endcase
    end
  end

  // Ack only answers a request that is still being held
  ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(app_req_ack) |-> app_req)
    else $error("app_req_ack rose while app_req was low");

endmodule

/* design/sdrc_req_fifo.sv */
//--------------------------------------------------------------------------
// Request buffer between address decode and the transfer controller
// Circular store with an occupancy count, entry visible one cycle after push
//--------------------------------------------------------------------------
`include "sdrc_settings.svh"

module sdrc_req_fifo (
  input logic        clk,
  input logic        reset,
  sdrc_req_if.buffer wr
);
  import sdrc_pkg::*;

  localparam int DEPTH = `SDRC_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  sdrc_req_t        mem [DEPTH];                   // Request storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;                         // Entries held
  logic             do_push;
  logic             do_pop;

  // Wrap at DEPTH, not only at a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign do_push    = wr.push && !wr.full;
  assign do_pop     = wr.pop && !wr.empty;
  assign wr.full    = (count == CNT_W'(DEPTH));
  assign wr.empty   = (count == '0);
  assign wr.pop_req = mem[rd_ptr];                 // Head shown while not empty

  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= wr.push_req;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_inc(rd_ptr);
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  // Both sides are expected to respect the flags
  no_push_full: assert property (@(posedge wr.clk) disable iff (reset)
    !(wr.push && wr.full))
    else $error("request pushed into a full buffer");

  no_pop_empty: assert property (@(posedge wr.clk) disable iff (reset)
    !(wr.pop && wr.empty))
    else $error("request popped from an empty buffer");

endmodule

/* design/sdrc_xfr_ctl.sv */
//--------------------------------------------------------------------------
// Transfer controller of the SDRAM controller
// Runs the power-up sequence, then one ACTIVE plus READ/WRITE with
// auto-precharge per buffered request, and returns read data in order
//--------------------------------------------------------------------------
`include "sdrc_settings.svh"

module sdrc_xfr_ctl (
  input  logic                   clk,
  input  logic                   reset,
  sdrc_req_if.consumer           rd,
  output logic                   sdr_cke,
  output logic                   sdr_cs_n,
  output logic                   sdr_ras_n,
  output logic                   sdr_cas_n,
  output logic                   sdr_we_n,
  output logic [`SDRC_BA_W-1:0]  sdr_ba,
  output logic [`SDRC_ROW_W-1:0] sdr_addr,
  output logic [`SDRC_DW-1:0]    sdr_dout,
  output logic                   sdr_den_n,       // Low drives DQ
  input  logic [`SDRC_DW-1:0]    pad_sdr_din,
  output logic [`SDRC_DW-1:0]    app_rd_data,
  output logic                   app_rd_valid,
  output logic                   sdr_init_done
);
  import sdrc_pkg::*;

  localparam int CNT_W     = $clog2(`SDRC_INIT_WAIT) + 1;  // Longest delay
  localparam int RD_PIPE_W = `SDRC_CAS + 2;                // CAS, pad, output

  sdrc_xfr_state_e         state;
  sdrc_xfr_state_e         state_nxt;
  sdrc_cmd_e               cmd_q;                  // Drives the command pins
  sdrc_cmd_e               cmd_nxt;
  logic [CNT_W-1:0]        cnt;                    // Shared delay counter
  logic [CNT_W-1:0]        cnt_nxt;
  logic                    second_rfsh;            // Second init refresh issued
  logic [`SDRC_BA_W-1:0]   ba_nxt;
  logic [`SDRC_ROW_W-1:0]  addr_nxt;
  sdrc_req_t               cur_req;                // Access in flight
  logic [RD_PIPE_W-1:0]    rd_pipe;                // READ marker per cycle
  logic [`SDRC_DW-1:0]     din_q;                  // Pad capture

  assign sdr_cke = 1'b1;                           // No power-down
  assign {sdr_cs_n, sdr_ras_n, sdr_cas_n, sdr_we_n} = cmd_q;

  // IDLE is only reached after init, so a pop never precedes init_done
  assign rd.pop = (state == IDLE) && !rd.empty;

  //------------------------------------------------------------------------
  // Command sequencing, every command lands on the pins one cycle later
  //------------------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    cmd_nxt   = NOP;
    cnt_nxt   = (cnt != '0) ? cnt - 1'b1 : cnt;
    ba_nxt    = '0;
    addr_nxt  = '0;
    case (state)
      INIT_WAIT: begin
        if (cnt == '0) begin
          cmd_nxt      = PRECHARGE;
          addr_nxt[10] = 1'b1;                     // All banks
          cnt_nxt      = CNT_W'(`SDRC_TRP - 1);
          state_nxt    = INIT_PRE;
        end
      end
      INIT_PRE: begin
        if (cnt == '0) begin
          cmd_nxt   = AUTO_REFRESH;
          cnt_nxt   = CNT_W'(`SDRC_TRFC - 1);
          state_nxt = INIT_RFSH;
        end
      end
      INIT_RFSH: begin
        if (cnt == '0 && !second_rfsh) begin
          cmd_nxt = AUTO_REFRESH;
          cnt_nxt = CNT_W'(`SDRC_TRFC - 1);
        end else if (cnt == '0) begin
          cmd_nxt   = LOAD_MODE;
          addr_nxt  = `SDRC_MODE_REG;
          cnt_nxt   = CNT_W'(`SDRC_TMRD - 1);
          state_nxt = INIT_MODE;
        end
      end
      INIT_MODE: begin
        if (cnt == '0)
          state_nxt = IDLE;
      end
      IDLE: begin
        if (rd.pop) begin
          cmd_nxt   = ACTIVE;
          ba_nxt    = rd.pop_req.ba;
          addr_nxt  = rd.pop_req.row;
          cnt_nxt   = CNT_W'(`SDRC_TRCD - 2);      // RW state is the last cycle
          state_nxt = ACT;
        end
      end
      ACT: begin
        if (cnt == '0)
          state_nxt = RW;
      end
      RW: begin
        if (cur_req.wr)
          cmd_nxt = WRITE;
        else
          cmd_nxt = READ;
        ba_nxt                    = cur_req.ba;
        addr_nxt[`SDRC_COL_W-1:0] = cur_req.col;
        addr_nxt[10]              = 1'b1;          // Auto-precharge
        cnt_nxt                   = CNT_W'(`SDRC_TRC - `SDRC_TRCD - 2);
        state_nxt                 = RECOVER;
      end
      RECOVER: begin
        if (cnt == '0)                             // IDLE is the final tRC cycle
          state_nxt = IDLE;
      end
      default: state_nxt = IDLE;
    endcase
  end

  //------------------------------------------------------------------------
  // Control registers
  //------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= INIT_WAIT;
      cnt           <= CNT_W'(`SDRC_INIT_WAIT - 1);
      cmd_q         <= NOP;
      second_rfsh   <= 1'b0;
      sdr_init_done <= 1'b0;
      sdr_den_n     <= 1'b1;
      rd_pipe       <= '0;
      app_rd_valid  <= 1'b0;
    end else begin
      state     <= state_nxt;
      cnt       <= cnt_nxt;
      cmd_q     <= cmd_nxt;
      sdr_den_n <= (cmd_nxt != WRITE);             // Data only with WRITE
      if (state == INIT_RFSH && cnt == '0)
        second_rfsh <= 1'b1;
      if (state == INIT_MODE && cnt == '0)
        sdr_init_done <= 1'b1;                     // tMRD after LOAD_MODE
      rd_pipe      <= {rd_pipe[RD_PIPE_W-2:0], cmd_nxt == READ};
      app_rd_valid <= rd_pipe[RD_PIPE_W-1];
    end
  end

  //------------------------------------------------------------------------
  // Address, write data and read return path
  //------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    sdr_ba   <= ba_nxt;
    sdr_addr <= addr_nxt;
    din_q    <= pad_sdr_din;                       // Data valid CAS after READ
    if (rd.pop)
      cur_req <= rd.pop_req;
    if (state == RW)
      sdr_dout <= cur_req.data;
    if (rd_pipe[RD_PIPE_W-1])
      app_rd_data <= din_q;
  end

  // Pin level check against the init sequence
  act_after_init: assert property (@(posedge clk) disable iff (reset)
    (cmd_q == ACTIVE) |-> sdr_init_done)
    else $error("ACTIVE issued before init done");

endmodule

/* design/sdrc_core.sv */
//--------------------------------------------------------------------------
// SDRAM controller top level for one x16 four-bank device
// Request decode, request buffer and transfer controller behind plain
// application and SDRAM pin ports
//--------------------------------------------------------------------------
`include "sdrc_settings.svh"

module sdrc_core (
  input  logic                    clk,
  input  logic                    reset,
  // Application side
  input  logic                    app_req,
  input  logic [`SDRC_APP_AW-1:0] app_req_addr,
  input  logic                    app_req_wr_n,
  input  logic [`SDRC_DW-1:0]     app_wr_data,
  output logic                    app_req_ack,
  output logic [`SDRC_DW-1:0]     app_rd_data,
  output logic                    app_rd_valid,
  output logic                    sdr_init_done,
  // SDRAM pins
  output logic                    sdr_cke,
  output logic                    sdr_cs_n,
  output logic                    sdr_ras_n,
  output logic                    sdr_cas_n,
  output logic                    sdr_we_n,
  output logic [1:0]              sdr_dqm,
  output logic [`SDRC_BA_W-1:0]   sdr_ba,
  output logic [`SDRC_ROW_W-1:0]  sdr_addr,
  output logic [`SDRC_DW-1:0]     sdr_dout,
  output logic                    sdr_den_n,
  input  logic [`SDRC_DW-1:0]     pad_sdr_din
);

  sdrc_req_if req_bus (.clk(clk));                 // Decoder to buffer to ctl

  assign sdr_dqm = 2'b00;                          // Every byte always enabled

  //------------------------------------------------------------------------
  // Producer, buffer, consumer
  //------------------------------------------------------------------------
  sdrc_req_gen u_req_gen (
    .clk          (clk),
    .reset        (reset),
    .app_req      (app_req),
    .app_req_addr (app_req_addr),
    .app_req_wr_n (app_req_wr_n),
    .app_wr_data  (app_wr_data),
    .app_req_ack  (app_req_ack),
    .req          (req_bus.producer)
  );

  sdrc_req_fifo u_req_fifo (
    .clk   (clk),
    .reset (reset),
    .wr    (req_bus.buffer)
  );

  sdrc_xfr_ctl u_xfr_ctl (
    .clk           (clk),
    .reset         (reset),
    .rd            (req_bus.consumer),
    .sdr_cke       (sdr_cke),
    .sdr_cs_n      (sdr_cs_n),
    .sdr_ras_n     (sdr_ras_n),
    .sdr_cas_n     (sdr_cas_n),
    .sdr_we_n      (sdr_we_n),
    .sdr_ba        (sdr_ba),
    .sdr_addr      (sdr_addr),
    .sdr_dout      (sdr_dout),
    .sdr_den_n     (sdr_den_n),
    .pad_sdr_din   (pad_sdr_din),
    .app_rd_data   (app_rd_data),
    .app_rd_valid  (app_rd_valid),
    .sdr_init_done (sdr_init_done)
  );

endmodule

/* tb/sdram_model.sv */
//--------------------------------------------------------------------------
// Behavioral x16 four-bank SDRAM for the controller testbench
// Stores WRITE data per bank, row and column, returns READ data after CAS
//--------------------------------------------------------------------------
`include "sdrc_settings.svh"

module sdram_model (
  input  logic                   clk,
  input  logic                   cs_n,
  input  logic                   ras_n,
  input  logic                   cas_n,
  input  logic                   we_n,
  input  logic [`SDRC_BA_W-1:0]  ba,
  input  logic [`SDRC_ROW_W-1:0] addr,
  input  logic [`SDRC_DW-1:0]    dq_in,          // Controller write data
  input  logic                   den_n,
  output logic [`SDRC_DW-1:0]    dq_out          // Toward pad_sdr_din
);
  timeunit 1ns;
  timeprecision 1ps;
  import sdrc_pkg::*;

  logic [`SDRC_ROW_W-1:0] open_row [4];          // Row opened by ACTIVE
  logic [`SDRC_DW-1:0]    mem [logic [`SDRC_APP_AW-1:0]];
  logic [`SDRC_DW-1:0]    rd_pipe [`SDRC_CAS];   // One stage per CAS cycle
  sdrc_cmd_e              cmd;
  logic [`SDRC_APP_AW-1:0] key;

  assign cmd    = sdrc_cmd_e'({cs_n, ras_n, cas_n, we_n});
  assign key    = {ba, open_row[ba], addr[`SDRC_COL_W-1:0]};
  assign dq_out = rd_pipe[`SDRC_CAS-1];

  initial begin
    for (int i = 0; i < 4; i++)
      open_row[i] = '0;
    for (int i = 0; i < `SDRC_CAS; i++)
      rd_pipe[i] = '0;
  end

  always @(posedge clk) begin
    if (cmd == ACTIVE)
      open_row[ba] <= addr;
    if (cmd == WRITE && !den_n)
      mem[key] = dq_in;
    // Unwritten locations read back as zero
    if (cmd == READ)
      rd_pipe[0] <= mem.exists(key) ? mem[key] : '0;
    else
      rd_pipe[0] <= '0;
    for (int i = 1; i < `SDRC_CAS; i++)
      rd_pipe[i] <= rd_pipe[i-1];
  end

endmodule

/* tb/sdrc_tb.sv */
//--------------------------------------------------------------------------
// Testbench of the SDRAM controller core with a behavioral SDRAM
// LFSR driven writes and reads, concurrent assertions check the pins
//--------------------------------------------------------------------------
`include "sdrc_settings.svh"

module sdrc_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import sdrc_pkg::*;

  localparam int TIMEOUT = 400;                  // Cycles per wait loop

  logic clk, reset, app_req, app_req_wr_n, app_req_ack, app_rd_valid;
  logic sdr_init_done, sdr_cke, sdr_cs_n, sdr_ras_n, sdr_cas_n, sdr_we_n;
  logic sdr_den_n;
  logic [1:0]               sdr_dqm;
  logic [`SDRC_APP_AW-1:0]  app_req_addr;
  logic [`SDRC_DW-1:0]      app_wr_data, app_rd_data, sdr_dout, pad_sdr_din;
  logic [`SDRC_BA_W-1:0]    sdr_ba;
  logic [`SDRC_ROW_W-1:0]   sdr_addr;

  // Expected requests in acceptance order
  logic [`SDRC_APP_AW-1:0]  exp_addr [64];
  logic                     exp_wr [64];
  logic [`SDRC_DW-1:0]      exp_data [64];
  logic [`SDRC_DW-1:0]      exp_rd [64];     // Read results in order
  logic [`SDRC_DW-1:0]      shadow [logic [`SDRC_APP_AW-1:0]];
  int req_cnt, rd_cnt;

  // Pin monitor state
  sdrc_cmd_e                cmd, exp_init_cmd;
  int                       cyc, last_cyc, act_cyc, act_idx, rd_got, acks, exp_gap;
  logic [2:0]               init_step;       // Init commands seen so far
  logic                     act_seen, ack_q, cur_wr;
  logic [`SDRC_APP_AW-1:0]  cur_addr;
  logic [`SDRC_DW-1:0]      cur_data, exp_rd_now;
  logic [`SDRC_APP_AW-1:0]  nxt_addr;
  logic [31:0]              lfsr;

  sdrc_core dut_i (.*);

  sdram_model sdram_i (
    .clk (clk), .cs_n (sdr_cs_n), .ras_n (sdr_ras_n), .cas_n (sdr_cas_n),
    .we_n (sdr_we_n), .ba (sdr_ba), .addr (sdr_addr), .dq_in (sdr_dout),
    .den_n (sdr_den_n), .dq_out (pad_sdr_din)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;                       // 8 ns period
  end

  assign cmd        = sdrc_cmd_e'({sdr_cs_n, sdr_ras_n, sdr_cas_n, sdr_we_n});
  assign nxt_addr   = exp_addr[act_idx];
  assign exp_rd_now = exp_rd[rd_got];

  // Init command expected after the precharge, and its distance
  assign exp_init_cmd = (init_step == 3'd3) ? LOAD_MODE : AUTO_REFRESH;
  assign exp_gap      = (init_step == 3'd1) ? `SDRC_TRP : `SDRC_TRFC;

  //------------------------------------------------------------------------
  // Pin monitor, sampled on the rising edge
  //------------------------------------------------------------------------
  always @(posedge clk) begin
    if (reset) begin
      cyc       <= 0;
      last_cyc  <= 0;
      act_cyc   <= 0;
      act_idx   <= 0;
      rd_got    <= 0;
      acks      <= 0;
      init_step <= '0;
      act_seen  <= 1'b0;
      ack_q     <= 1'b0;
    end else begin
      cyc   <= cyc + 1;
      ack_q <= app_req_ack;
      if (init_step < 3'd4 && cmd != NOP) begin  // Next init command
        init_step <= init_step + 3'd1;
        last_cyc  <= cyc;
      end
      if (cmd == ACTIVE) begin
        act_seen <= 1'b1;
        act_cyc  <= cyc;
        act_idx  <= act_idx + 1;
        cur_addr <= nxt_addr;
        cur_wr   <= exp_wr[act_idx];
        cur_data <= exp_data[act_idx];
      end
      if (app_req_ack && !ack_q)
        acks <= acks + 1;
      if (app_rd_valid)
        rd_got <= rd_got + 1;
    end
  end

  //------------------------------------------------------------------------
  // Failure reporting
  //------------------------------------------------------------------------
  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic print_mismatch(input string sig, input logic [31:0] exp,
                                input logic [31:0] act);
    $display("mismatch at %0t: %s expected %h actual %h", $time, sig, exp, act);
    abort_run();
  endtask

  task automatic report_failure(input string msg);
    $display("error at %0t: %s", $time, msg);
    abort_run();
  endtask

  //------------------------------------------------------------------------
  // Init sequence
  //------------------------------------------------------------------------
  a_init_nop: assert property (@(posedge clk) disable iff (reset)
    init_step == 3'd0 |-> cmd inside {NOP, PRECHARGE})
    else report_failure("command other than NOP before the initial precharge");
  a_init_wait: assert property (@(posedge clk) disable iff (reset)
    init_step == 3'd0 && cmd == PRECHARGE |-> cyc == `SDRC_INIT_WAIT)
    else print_mismatch("power-up NOP cycles", `SDRC_INIT_WAIT, $sampled(cyc));
  a_pre_all: assert property (@(posedge clk) disable iff (reset)
    cmd == PRECHARGE |-> sdr_addr[10])
    else print_mismatch("sdr_addr[10]", 1, $sampled(sdr_addr[10]));
  a_init_cmd: assert property (@(posedge clk) disable iff (reset)
    init_step inside {3'd1, 3'd2, 3'd3} && cmd != NOP |-> cmd == exp_init_cmd)
    else print_mismatch("init command", exp_init_cmd, $sampled(cmd));
  a_init_gap: assert property (@(posedge clk) disable iff (reset)
    init_step inside {3'd1, 3'd2, 3'd3} && cmd != NOP |-> cyc - last_cyc == exp_gap)
    else print_mismatch("init command spacing", exp_gap, $sampled(cyc - last_cyc));
  a_mode: assert property (@(posedge clk) disable iff (reset)
    cmd == LOAD_MODE |-> sdr_addr == `SDRC_MODE_REG)
    else print_mismatch("sdr_addr", `SDRC_MODE_REG, $sampled(sdr_addr));
  a_done_gap: assert property (@(posedge clk) disable iff (reset)
    $rose(sdr_init_done) |-> init_step == 3'd4 && cyc - last_cyc == `SDRC_TMRD)
    else report_failure("sdr_init_done rose at the wrong time");
  a_act_init: assert property (@(posedge clk) disable iff (reset)
    cmd == ACTIVE |-> sdr_init_done)
    else report_failure("ACTIVE issued before sdr_init_done");
  a_cke: assert property (@(posedge clk) disable iff (reset) sdr_cke)
    else print_mismatch("sdr_cke", 1, $sampled(sdr_cke));
  a_dqm: assert property (@(posedge clk) disable iff (reset) sdr_dqm == 2'b00)
    else print_mismatch("sdr_dqm", 0, $sampled(sdr_dqm));

  //------------------------------------------------------------------------
  // Handshake and back-pressure
  //------------------------------------------------------------------------
  a_ack_rise: assert property (@(posedge clk) disable iff (reset)
    $rose(app_req_ack) |-> app_req)
    else report_failure("app_req_ack rose while app_req was low");
  a_ack_fall: assert property (@(posedge clk) disable iff (reset)
    $fell(app_req_ack) |-> !app_req)
    else report_failure("app_req_ack fell while app_req was high");
  a_backpress: assert property (@(posedge clk) disable iff (reset)
    $rose(app_req_ack) && acks >= `SDRC_FIFO_DEPTH |-> act_seen)
    else report_failure("request acknowledged beyond buffer depth before any access");

  //------------------------------------------------------------------------
  // Access sequence and data
  //------------------------------------------------------------------------
  a_act_addr: assert property (@(posedge clk) disable iff (reset)
    cmd == ACTIVE |-> {sdr_ba, sdr_addr} ==
      {nxt_addr[`SDRC_APP_AW-1 -: `SDRC_BA_W], nxt_addr[`SDRC_COL_W +: `SDRC_ROW_W]})
    else print_mismatch("sdr_ba/sdr_addr at ACTIVE",
      {nxt_addr[`SDRC_APP_AW-1 -: `SDRC_BA_W], nxt_addr[`SDRC_COL_W +: `SDRC_ROW_W]},
      $sampled({sdr_ba, sdr_addr}));
  a_rw_gap: assert property (@(posedge clk) disable iff (reset)
    cmd inside {READ, WRITE} |-> cyc - act_cyc == `SDRC_TRCD)
    else print_mismatch("ACTIVE to READ/WRITE cycles", `SDRC_TRCD,
      $sampled(cyc - act_cyc));
  a_rw_kind: assert property (@(posedge clk) disable iff (reset)
    cmd inside {READ, WRITE} |-> cmd == (cur_wr ? WRITE : READ))
    else print_mismatch("column command", cur_wr ? WRITE : READ, $sampled(cmd));
  a_rw_addr: assert property (@(posedge clk) disable iff (reset)
    cmd inside {READ, WRITE} |-> {sdr_ba, sdr_addr} ==
      {cur_addr[`SDRC_APP_AW-1 -: `SDRC_BA_W], 12'h400 | 12'(cur_addr[`SDRC_COL_W-1:0])})
    else print_mismatch("sdr_ba/sdr_addr at READ/WRITE",
      {cur_addr[`SDRC_APP_AW-1 -: `SDRC_BA_W], 12'h400 | 12'(cur_addr[`SDRC_COL_W-1:0])},
      $sampled({sdr_ba, sdr_addr}));
  a_wr_data: assert property (@(posedge clk) disable iff (reset)
    cmd == WRITE |-> sdr_dout == cur_data)
    else print_mismatch("sdr_dout", cur_data, $sampled(sdr_dout));
  a_den: assert property (@(posedge clk) disable iff (reset)
    sdr_den_n == (cmd != WRITE))
    else print_mismatch("sdr_den_n", cmd != WRITE, $sampled(sdr_den_n));
  a_rd_data: assert property (@(posedge clk) disable iff (reset)
    app_rd_valid |-> rd_got < rd_cnt && app_rd_data == exp_rd_now)
    else print_mismatch("app_rd_data", exp_rd_now, $sampled(app_rd_data));
  a_trc: assert property (@(posedge clk) disable iff (reset)
    cmd == ACTIVE && act_seen |-> cyc - act_cyc >= `SDRC_TRC)
    else print_mismatch("ACTIVE to ACTIVE cycles", `SDRC_TRC, $sampled(cyc - act_cyc));

  //------------------------------------------------------------------------
  // Stimulus
  //------------------------------------------------------------------------
  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // One full four-phase handshake
  task automatic send_request(input logic wr, input logic [`SDRC_APP_AW-1:0] addr,
                              input logic [`SDRC_DW-1:0] data);
    int n;
    exp_addr[req_cnt] = addr;
    exp_wr[req_cnt]   = wr;
    exp_data[req_cnt] = data;
    req_cnt++;
    if (wr)
      shadow[addr] = data;
    else begin
      exp_rd[rd_cnt] = shadow.exists(addr) ? shadow[addr] : '0;
      rd_cnt++;
    end
    app_req_addr <= addr;
    app_req_wr_n <= ~wr;
    app_wr_data  <= data;
    app_req      <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!app_req_ack && n < TIMEOUT);
    if (!app_req_ack)
      report_failure("timeout waiting for app_req_ack to rise");
    app_req <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (app_req_ack && n < TIMEOUT);
    if (app_req_ack)
      report_failure("timeout waiting for app_req_ack to fall");
  endtask

  initial begin
    logic [31:0]             r;
    logic [`SDRC_APP_AW-1:0] waddr [6];
    int                      n;
    lfsr = 32'hcb36;
    req_cnt = 0;
    rd_cnt = 0;
    reset = 1'b1;
    app_req = 1'b0;
    app_req_addr = '0;
    app_req_wr_n = 1'b1;
    app_wr_data = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // Six writes while init is still running, last two meet a full buffer
    for (int i = 0; i < 6; i++) begin
      r = take_bits(`SDRC_APP_AW);
      waddr[i] = r[`SDRC_APP_AW-1:0];
      r = take_bits(`SDRC_DW);
      send_request(1'b1, waddr[i], r[`SDRC_DW-1:0]);
    end
    for (int i = 0; i < 6; i++) begin              // Random read-back
      r = take_bits(3);
      send_request(1'b0, waddr[r % 6], '0);
    end
    do
      r = take_bits(`SDRC_APP_AW);
    while (shadow.exists(r[`SDRC_APP_AW-1:0]));
    send_request(1'b0, r[`SDRC_APP_AW-1:0], '0);   // Never written
    r = take_bits(`SDRC_DW);
    send_request(1'b1, waddr[0], r[`SDRC_DW-1:0]); // Overwrite, then read
    send_request(1'b0, waddr[0], '0);

    n = 0;
    while ((act_idx < req_cnt || rd_got < rd_cnt) && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (act_idx < req_cnt || rd_got < rd_cnt)
      report_failure("timeout waiting for outstanding accesses");
    repeat (`SDRC_TRC) @(posedge clk);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+include
design/sdrc_pkg.sv
design/sdrc_req_if.sv
design/sdrc_req_gen.sv
design/sdrc_req_fifo.sv
design/sdrc_xfr_ctl.sv
design/sdrc_core.sv
tb/sdram_model.sv
tb/sdrc_tb.sv

/* run.sh */
#!/bin/sh
# Build the SDRAM controller testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module sdrc_tb -o sim_sdrc

./obj_dir/sim_sdrc 2>&1 | tee sim.log

if grep -q "TEST PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
